// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_zx_mem_map
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+tb
src/zx_bus_pkg.sv
src/zx_map_pkg.sv
src/port_decoder.sv
src/window_pager.sv
src/dos_ctrl.sv
src/addr_mapper.sv
src/zx_mem_map.sv
tb/tb_clock.sv
tb/tb_zx_mem_map.sv

// ==== src/addr_mapper.sv ====
`timescale 1ns/1ps

module addr_mapper
(
	input  logic                   fclk,
	input  logic                   rst_n,

	input  logic                   lk_valid,
	input  logic                   lk_rom,
	input  zx_map_pkg::page_t      lk_page,
	input  zx_map_pkg::waddr_t     lk_offset,

	output logic                   map_valid,
	output logic                   map_rom,
	output zx_map_pkg::page_t      map_page,
	output zx_map_pkg::phys_addr_t map_addr
);

	//////////////////////////////////////////////////
	// second pipeline stage
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			map_valid <= 1'b0;
		else
			map_valid <= lk_valid;
	end

	// page on top, 16k offset below
	always_ff @(posedge fclk)
	begin
		if (lk_valid)
		begin
			map_page <= lk_page;
			map_rom  <= lk_rom;
			map_addr <= {lk_page, lk_offset};
		end
	end

	// a result is never produced without a lookup behind it
	a_valid_from_lookup: assert property (
		@(posedge fclk) disable iff (!rst_n)
		map_valid |-> $past(lk_valid)
	);

endmodule

// ==== src/dos_ctrl.sv ====
`timescale 1ns/1ps

module dos_ctrl
(
	input  logic               fclk,
	input  logic               rst_n,

	input  logic               mem_req,
	input  logic               mem_m1,
	input  zx_bus_pkg::zaddr_t mem_addr,

	input  logic               win0_rom,
	input  logic               rom48,

	output logic               dos
);

	import zx_map_pkg::*;

	logic fetch;
	logic dos_on;
	logic dos_off;

	assign fetch = mem_req && mem_m1;

	// entry only from the 48k basic rom
	assign dos_on  = fetch && (mem_addr[15:8] == DOS_ENTRY_HIGH) && win0_rom && rom48;

	// any fetch above 3FFF leaves dos
	assign dos_off = fetch && (mem_addr[15] || mem_addr[14]);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

	a_dos_on_fetch: assert property (
		@(posedge fclk) disable iff (!rst_n)
		!fetch |=> $stable(dos)
	);

endmodule

// ==== src/port_decoder.sv ====
`timescale 1ns/1ps

module port_decoder
(
	input  logic                 fclk,
	input  logic                 rst_n,

	input  logic                 io_wr,
	input  zx_bus_pkg::zaddr_t   io_addr,
	input  zx_bus_pkg::zdata_t   io_data,

	// 7ffd lock bit from the pager
	input  logic                 lock,

	output logic                 p7ffd_we,
	output logic                 win_we,
	output logic                 win_ram,
	output logic                 pen_we,
	output zx_map_pkg::win_sel_t win_sel,

	output logic                 beep
);

	import zx_bus_pkg::*;

	logic [7:0] addr_low;
	logic       hit_7ffd;
	logic       beep_we;

	assign addr_low = io_addr[7:0];

	// full 16 bit match, ignored once locked
	assign hit_7ffd = (io_addr == PORT_7FFD) && !lock;

	//////////////////////////////////////////////////
	// write strobes, in priority order
	//////////////////////////////////////////////////

	always_comb
	begin
		p7ffd_we = 1'b0;
		win_we   = 1'b0;
		pen_we   = 1'b0;
		beep_we  = 1'b0;

		if (io_wr)
		begin
			if (hit_7ffd)
				p7ffd_we = 1'b1;
			else if (addr_low == PORT_F7_LOW)
				win_we = 1'b1;
			else if (addr_low == PORT_77_LOW)
				pen_we = 1'b1;
			else if (addr_low == PORT_FE_LOW)
				beep_we = 1'b1;
		end
	end

	// window number and rom/ram flag ride on the high address bits
	assign win_sel = io_addr[15:14];
	assign win_ram = io_addr[13];

	//////////////////////////////////////////////////
	// beeper
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			beep <= 1'b0;
		else if (beep_we)
			beep <= io_data[BEEP_BIT];
	end

	// only one register may be written per port access
	a_one_strobe: assert property (
		@(posedge fclk) disable iff (!rst_n)
		$onehot0({p7ffd_we, win_we, pen_we, beep_we})
	);

endmodule

// ==== src/window_pager.sv ====
`timescale 1ns/1ps

module window_pager
(
	input  logic                 fclk,
	input  logic                 rst_n,

	input  zx_bus_pkg::zdata_t   io_data,
	input  logic                 p7ffd_we,
	input  logic                 win_we,
	input  logic                 win_ram,
	input  logic                 pen_we,
	input  zx_map_pkg::win_sel_t win_sel,

	input  logic                 dos,

	input  logic                 mem_req,
	input  zx_bus_pkg::zaddr_t   mem_addr,

	output logic                 lock,
	output logic                 rom48,
	output logic                 win0_rom,

	output logic                 lk_valid,
	output logic                 lk_rom,
	output zx_map_pkg::page_t    lk_page,
	output zx_map_pkg::waddr_t   lk_offset
);

	import zx_bus_pkg::*;
	import zx_map_pkg::*;

	zdata_t   p7ffd;
	logic     pen;
	page_t    win_page [NUM_WIN];
	logic     win_is_ram [NUM_WIN];

	page_t    pent_page [NUM_WIN];
	win_sel_t req_win;
	page_t    sel_page;
	logic     sel_rom;

	//////////////////////////////////////////////////
	// paging registers
	//////////////////////////////////////////////////

	// lock sits inside 7ffd, writes are blocked upstream once it is set
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd <= '0;
			pen   <= 1'b0;
			for (int i = 0; i < NUM_WIN; i++)
			begin
				win_page[i]   <= '0;
				win_is_ram[i] <= 1'b0;
			end
		end
		else
		begin
			if (p7ffd_we)
				p7ffd <= io_data;
			if (pen_we)
				pen <= io_data[0];
			if (win_we)
			begin
				win_page[win_sel]   <= io_data;
				win_is_ram[win_sel] <= win_ram;
			end
		end
	end

	assign lock  = p7ffd[5];
	assign rom48 = p7ffd[4];

	//////////////////////////////////////////////////
	// window lookup
	//////////////////////////////////////////////////

	// pentagon layout, rom in window 0 and ram elsewhere
	always_comb
	begin
		pent_page[0] = {6'd0, dos, rom48};
		pent_page[1] = PENT_WIN1_PAGE;
		pent_page[2] = PENT_WIN2_PAGE;
		pent_page[3] = {5'd0, p7ffd[2:0]};
	end

	assign req_win  = mem_addr[15:14];
	assign sel_page = pen ? win_page[req_win] : pent_page[req_win];
	assign sel_rom  = pen ? !win_is_ram[req_win] : (req_win == 2'd0);

	// dos logic needs to know if rom is under 0000-3FFF
	assign win0_rom = pen ? !win_is_ram[0] : 1'b1;

	// first pipeline stage
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			lk_valid <= 1'b0;
		else
			lk_valid <= mem_req;
	end

	always_ff @(posedge fclk)
	begin
		if (mem_req)
		begin
			lk_page   <= sel_page;
			lk_rom    <= sel_rom;
			lk_offset <= mem_addr[13:0];
		end
	end

endmodule

// ==== src/zx_bus_pkg.sv ====
package zx_bus_pkg;

	//////////////////////////////////////////////////
	// cpu side bus types
	//////////////////////////////////////////////////

	// z80 address and data
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	//////////////////////////////////////////////////
	// i/o port addresses
	//////////////////////////////////////////////////

	// beeper and border, decoded on low byte only
	localparam logic [7:0] PORT_FE_LOW = 8'hFE;

	// pentagon paging port, full decode
	localparam zaddr_t PORT_7FFD = 16'h7FFD;

	// atm window page port
	// high address bits pick the window and the ram flag
	localparam logic [7:0] PORT_F7_LOW = 8'hF7;

	// atm pager enable
	localparam logic [7:0] PORT_77_LOW = 8'h77;

	// data bit of port fe that drives the speaker
	localparam int BEEP_BIT = 4;

endpackage

// ==== src/zx_map_pkg.sv ====
package zx_map_pkg;

	//////////////////////////////////////////////////
	// memory windows
	//////////////////////////////////////////////////

	// four 16k windows over the z80 address space
	localparam int NUM_WIN = 4;

	// window index, from cpu address bits 15:14
	typedef logic [1:0] win_sel_t;

	//////////////////////////////////////////////////
	// physical memory
	//////////////////////////////////////////////////

	typedef logic [7:0]  page_t;
	typedef logic [13:0] waddr_t;

	// page in the upper bits, window offset below
	typedef logic [21:0] phys_addr_t;

	// fixed ram pages of the pentagon layout
	localparam page_t PENT_WIN1_PAGE = 8'd5;
	localparam page_t PENT_WIN2_PAGE = 8'd2;

	// opcode fetches from 3Dxx switch the dos rom in
	localparam logic [7:0] DOS_ENTRY_HIGH = 8'h3D;

endpackage

// ==== src/zx_mem_map.sv ====
`timescale 1ns/1ps

module zx_mem_map
(
	input  logic                   fclk,
	input  logic                   rst_n,

	input  logic                   io_wr,
	input  zx_bus_pkg::zaddr_t     io_addr,
	input  zx_bus_pkg::zdata_t     io_data,

	input  logic                   mem_req,
	input  logic                   mem_m1,
	input  zx_bus_pkg::zaddr_t     mem_addr,

	output logic                   map_valid,
	output logic                   map_rom,
	output zx_map_pkg::page_t      map_page,
	output zx_map_pkg::phys_addr_t map_addr,

	output logic                   dos,
	output logic                   beep
);

	import zx_map_pkg::*;

	// port decoder to pager
	logic     p7ffd_we;
	logic     win_we;
	logic     win_ram;
	logic     pen_we;
	win_sel_t win_sel;
	logic     lock;

	// pager to dos logic
	logic     rom48;
	logic     win0_rom;

	// lookup stage
	logic     lk_valid;
	logic     lk_rom;
	page_t    lk_page;
	waddr_t   lk_offset;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	port_decoder i_port_decoder
	(
		.fclk    (fclk    ),
		.rst_n   (rst_n   ),
		.io_wr   (io_wr   ),
		.io_addr (io_addr ),
		.io_data (io_data ),
		.lock    (lock    ),
		.p7ffd_we(p7ffd_we),
		.win_we  (win_we  ),
		.win_ram (win_ram ),
		.pen_we  (pen_we  ),
		.win_sel (win_sel ),
		.beep    (beep    )
	);

	dos_ctrl i_dos_ctrl
	(
		.fclk    (fclk    ),
		.rst_n   (rst_n   ),
		.mem_req (mem_req ),
		.mem_m1  (mem_m1  ),
		.mem_addr(mem_addr),
		.win0_rom(win0_rom),
		.rom48   (rom48   ),
		.dos     (dos     )
	);

	//////////////////////////////////////////////////
	// mapping pipeline
	//////////////////////////////////////////////////

	window_pager i_window_pager
	(
		.fclk     (fclk     ),
		.rst_n    (rst_n    ),
		.io_data  (io_data  ),
		.p7ffd_we (p7ffd_we ),
		.win_we   (win_we   ),
		.win_ram  (win_ram  ),
		.pen_we   (pen_we   ),
		.win_sel  (win_sel  ),
		.dos      (dos      ),
		.mem_req  (mem_req  ),
		.mem_addr (mem_addr ),
		.lock     (lock     ),
		.rom48    (rom48    ),
		.win0_rom (win0_rom ),
		.lk_valid (lk_valid ),
		.lk_rom   (lk_rom   ),
		.lk_page  (lk_page  ),
		.lk_offset(lk_offset)
	);

	addr_mapper i_addr_mapper
	(
		.fclk     (fclk     ),
		.rst_n    (rst_n    ),
		.lk_valid (lk_valid ),
		.lk_rom   (lk_rom   ),
		.lk_page  (lk_page  ),
		.lk_offset(lk_offset),
		.map_valid(map_valid),
		.map_rom  (map_rom  ),
		.map_page (map_page ),
		.map_addr (map_addr )
	);

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
(
	output logic fclk,
	output logic rst_n
);

	// 8 ns period
	initial
	begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	// reset held for 16 rising edges, released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (16) @(posedge fclk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// ==== tb/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int err_count   = 0;

// page, rom flag and physical address of one mapping result
task automatic check_map
(
	input zx_map_pkg::page_t      got_page,
	input logic                   got_rom,
	input zx_map_pkg::phys_addr_t got_addr,
	input zx_map_pkg::page_t      exp_page,
	input logic                   exp_rom,
	input zx_map_pkg::phys_addr_t exp_addr
);
	check_count++;
	if (got_page !== exp_page || got_rom !== exp_rom || got_addr !== exp_addr)
	begin
		err_count++;
		$display("** Error at %0d ns: map page %h rom %b addr %h, expected page %h rom %b addr %h",
			$time, got_page, got_rom, got_addr, exp_page, exp_rom, exp_addr);
	end
endtask

// single status bits such as dos, beep and map_valid
task automatic check_bit(input logic got, input logic exp, input string name);
	check_count++;
	if (got !== exp)
	begin
		err_count++;
		$display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
	end
endtask

`endif

// ==== tb/tb_zx_mem_map.sv ====
`timescale 1ns/1ps

module tb_zx_mem_map;

	import zx_bus_pkg::*;
	import zx_map_pkg::*;

	typedef struct packed {
		logic   io;
		zaddr_t addr;
		zdata_t data;
		logic   m1;
		page_t  page;
		logic   rom;
		logic   dos;
		logic   beep;
	} step_t;

	localparam int NUM_STEPS   = 32;
	localparam int RAND_STEPS  = 40;
	localparam int WAIT_CYCLES = 10;

	logic       fclk;
	logic       rst_n;
	logic       io_wr;
	zaddr_t     io_addr;
	zdata_t     io_data;
	logic       mem_req;
	logic       mem_m1;
	zaddr_t     mem_addr;
	logic       map_valid;
	logic       map_rom;
	page_t      map_page;
	phys_addr_t map_addr;
	logic       dos;
	logic       beep;

	int   seed = 32'h5902;
	logic timed_out;

	`include "tb_checks.svh"

	// reference model state
	zdata_t m_7ffd;
	logic   m_pen;
	page_t  m_page [NUM_WIN];
	logic   m_ram [NUM_WIN];
	logic   m_dos;
	logic   m_beep;

	//////////////////////////////////////////////////
	// directed steps
	// io, addr, data, m1, page, rom, dos, beep
	//////////////////////////////////////////////////

	step_t steps [NUM_STEPS] = '{
		// pentagon layout after reset
		'{1'b0, 16'h0123, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0},
		'{1'b0, 16'h4567, 8'h00, 1'b0, 8'h05, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h89AB, 8'h00, 1'b0, 8'h02, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'hC000, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		// 7ffd with rom48 and ram page 3
		'{1'b1, 16'h7FFD, 8'h13, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'hC010, 8'h00, 1'b0, 8'h03, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h0010, 8'h00, 1'b0, 8'h01, 1'b1, 1'b0, 1'b0},
		// dos entry and exit
		'{1'b0, 16'h3D2F, 8'h00, 1'b0, 8'h01, 1'b1, 1'b0, 1'b0},
		'{1'b0, 16'h3D00, 8'h00, 1'b1, 8'h01, 1'b1, 1'b1, 1'b0},
		'{1'b0, 16'h0100, 8'h00, 1'b0, 8'h03, 1'b1, 1'b1, 1'b0},
		'{1'b0, 16'h8000, 8'h00, 1'b1, 8'h02, 1'b0, 1'b0, 1'b0},
		// beeper and unused ports
		'{1'b1, 16'h00FE, 8'h10, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1},
		'{1'b1, 16'h00FB, 8'hEF, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1},
		'{1'b1, 16'h7EFD, 8'h07, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1},
		'{1'b0, 16'hC000, 8'h00, 1'b0, 8'h03, 1'b0, 1'b0, 1'b1},
		'{1'b1, 16'h12FE, 8'hEF, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		// lock bit
		'{1'b1, 16'h7FFD, 8'h26, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'hC020, 8'h00, 1'b0, 8'h06, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h0020, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0},
		'{1'b1, 16'h7FFD, 8'h17, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'hC030, 8'h00, 1'b0, 8'h06, 1'b0, 1'b0, 1'b0},
		// atm pager
		'{1'b1, 16'h0077, 8'h01, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h4000, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0, 1'b0},
		'{1'b1, 16'h60F7, 8'h21, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h4444, 8'h00, 1'b0, 8'h21, 1'b0, 1'b0, 1'b0},
		'{1'b1, 16'h00F7, 8'h0A, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h0123, 8'h00, 1'b0, 8'h0A, 1'b1, 1'b0, 1'b0},
		'{1'b1, 16'hE0F7, 8'h80, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'hFFFF, 8'h00, 1'b0, 8'h80, 1'b0, 1'b0, 1'b0},
		'{1'b1, 16'h0077, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'h4000, 8'h00, 1'b0, 8'h05, 1'b0, 1'b0, 1'b0},
		'{1'b0, 16'hC000, 8'h00, 1'b0, 8'h06, 1'b0, 1'b0, 1'b0}
	};

	tb_clock i_clock
	(
		.fclk (fclk ),
		.rst_n(rst_n)
	);

	zx_mem_map i_dut
	(
		.fclk     (fclk     ),
		.rst_n    (rst_n    ),
		.io_wr    (io_wr    ),
		.io_addr  (io_addr  ),
		.io_data  (io_data  ),
		.mem_req  (mem_req  ),
		.mem_m1   (mem_m1   ),
		.mem_addr (mem_addr ),
		.map_valid(map_valid),
		.map_rom  (map_rom  ),
		.map_page (map_page ),
		.map_addr (map_addr ),
		.dos      (dos      ),
		.beep     (beep     )
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic void model_io(input zaddr_t a, input zdata_t d);
		if (a == PORT_7FFD)
		begin
			if (!m_7ffd[5])
				m_7ffd = d;
		end
		else if (a[7:0] == PORT_F7_LOW)
		begin
			m_page[a[15:14]] = d;
			m_ram[a[15:14]]  = a[13];
		end
		else if (a[7:0] == PORT_77_LOW)
			m_pen = d[0];
		else if (a[7:0] == PORT_FE_LOW)
			m_beep = d[4];
	endfunction

	function automatic void model_map(input zaddr_t a, output page_t p, output logic rom);
		if (m_pen)
		begin
			p   = m_page[a[15:14]];
			rom = !m_ram[a[15:14]];
		end
		else
		begin
			rom = (a[15:14] == 2'd0);
			case (a[15:14])
				2'd0:    p = 8'(m_dos) * 8'd2 + 8'(m_7ffd[4]);
				2'd1:    p = 8'd5;
				2'd2:    p = 8'd2;
				default: p = {5'd0, m_7ffd[2:0]};
			endcase
		end
	endfunction

	// dos only moves on opcode fetches, after the mapping of that fetch
	function automatic void model_fetch(input zaddr_t a, input logic m1);
		logic rom0;
		rom0 = m_pen ? !m_ram[0] : 1'b1;
		if (m1 && a[15:8] == 8'h3D && rom0 && m_7ffd[4])
			m_dos = 1'b1;
		else if (m1 && (a[15] || a[14]))
			m_dos = 1'b0;
	endfunction

	// advance the model by one step and return the step with its expected results
	function automatic step_t predict(input step_t s);
		step_t e;
		page_t p;
		logic  r;
		e = s;
		if (s.io)
			model_io(s.addr, s.data);
		else
		begin
			model_map(s.addr, p, r);
			e.page = p;
			e.rom  = r;
			model_fetch(s.addr, s.m1);
		end
		e.dos  = m_dos;
		e.beep = m_beep;
		return e;
	endfunction

	function automatic step_t random_step();
		step_t       s;
		logic [31:0] r;
		logic [31:0] a;
		r      = $random(seed);
		a      = $random(seed);
		s      = '0;
		s.io   = r[0];
		s.m1   = r[1];
		s.addr = a[15:0];
		s.data = a[23:16];
		if (s.io)
		begin
			case (r[3:2])
				2'd0:    s.addr[7:0] = PORT_FE_LOW;
				2'd1:    s.addr[7:0] = PORT_F7_LOW;
				2'd2:    s.addr[7:0] = PORT_77_LOW;
				default: s.addr = PORT_7FFD;
			endcase
		end
		return predict(s);
	endfunction

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic run_step(input step_t s, input string tag);
		int   lat;
		int   errs;
		logic got;
		errs = err_count;
		if (s.io)
		begin
			io_wr   = 1'b1;
			io_addr = s.addr;
			io_data = s.data;
			@(posedge fclk);
			#1;
			io_wr = 1'b0;
		end
		else
		begin
			mem_req  = 1'b1;
			mem_addr = s.addr;
			mem_m1   = s.m1;
			lat      = 0;
			got      = 1'b0;
			while (!got && !timed_out)
			begin
				@(posedge fclk);
				#1;
				mem_req = 1'b0;
				lat++;
				if (map_valid === 1'b1)
					got = 1'b1;
				else if (lat >= WAIT_CYCLES)
				begin
					$display("%s: no map_valid within %0d cycles of the request", tag, WAIT_CYCLES);
					timed_out = 1'b1;
				end
			end
			if (got)
			begin
				if (lat != 2)
				begin
					err_count++;
					$display("** Error at %0d ns: map_valid %0d cycles after mem_req, expected 2",
						$time, lat);
				end
				check_map(map_page, map_rom, map_addr, s.page, s.rom, {s.page, s.addr[13:0]});
			end
		end
		check_bit(dos, s.dos, "dos");
		check_bit(beep, s.beep, "beep");
		$display("%-9s %s addr %h data %h m1 %b : %s", tag, s.io ? "io " : "mem", s.addr, s.data,
			s.m1, (err_count == errs && !timed_out) ? "ok" : "FAILED");
	endtask

	// one request per cycle into all four windows
	task automatic run_burst();
		page_t  exp_page [NUM_WIN];
		logic   exp_rom [NUM_WIN];
		zaddr_t addr [NUM_WIN];
		int     errs;
		errs = err_count;
		for (int i = 0; i < NUM_WIN; i++)
		begin
			addr[i] = {2'(i), 4'(i), 10'h155};
			model_map(addr[i], exp_page[i], exp_rom[i]);
		end
		for (int c = 0; c <= NUM_WIN; c++)
		begin
			mem_req  = (c < NUM_WIN);
			mem_addr = addr[c % NUM_WIN];
			mem_m1   = 1'b0;
			@(posedge fclk);
			#1;
			// result k shows up two edges after request k
			check_bit(map_valid, (c != 0), "map_valid");
			if (c != 0)
				check_map(map_page, map_rom, map_addr, exp_page[c - 1], exp_rom[c - 1],
					{exp_page[c - 1], addr[c - 1][13:0]});
		end
		$display("burst     four back-to-back requests : %s", (err_count == errs) ? "ok" : "FAILED");
	endtask

	initial
	begin
		int    cnt;
		step_t e;
		io_wr     = 1'b0;
		io_addr   = '0;
		io_data   = '0;
		mem_req   = 1'b0;
		mem_m1    = 1'b0;
		mem_addr  = '0;
		timed_out = 1'b0;
		m_7ffd    = '0;
		m_pen     = 1'b0;
		m_dos     = 1'b0;
		m_beep    = 1'b0;
		for (int i = 0; i < NUM_WIN; i++)
		begin
			m_page[i] = '0;
			m_ram[i]  = 1'b0;
		end

		cnt = 0;
		while (rst_n !== 1'b1 && !timed_out)
		begin
			@(posedge fclk);
			cnt++;
			if (cnt > 40)
			begin
				$display("reset was not released within 40 cycles");
				timed_out = 1'b1;
			end
		end
		#1;

		if (!timed_out)
			run_burst();

		for (int i = 0; i < NUM_STEPS; i++)
		begin
			if (!timed_out)
			begin
				e = predict(steps[i]);
				if (e !== steps[i])
				begin
					err_count++;
					$display("reference model disagrees with the table at step %0d", i);
				end
				run_step(steps[i], $sformatf("step %0d", i));
			end
		end

		for (int i = 0; i < RAND_STEPS; i++)
		begin
			if (!timed_out)
				run_step(random_step(), $sformatf("rand %0d", i));
		end

		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0 && !timed_out)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
